// ==== files.f ====
+incdir+include
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_alu_core.sv
testbench/tb_rv_alu_core.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

obj_dir/Vtb_rv_alu_core: files.f
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module tb_rv_alu_core -o Vtb_rv_alu_core

test: obj_dir/Vtb_rv_alu_core
	@out="$$(./obj_dir/Vtb_rv_alu_core)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// ==== testbench/tb_rv_alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tb_rv_alu_core;

	localparam int MAX_INST    = 128;
	localparam int MAX_DELAY   = 8;
	localparam int HOLD_CYCLES = 40;
	localparam int CYCLE_LIMIT = MAX_INST * (MAX_DELAY + 3) + HOLD_CYCLES + 200;

	logic clock;
	logic rst_n;
	logic inst_valid;
	logic [31:0] inst_w;
	logic [31:0] pc_w;
	logic in_credit;
	logic res_valid;
	logic [31:0] res_pc;
	logic [4:0] res_rd;
	logic [31:0] res_value;
	rv_ctrl_pkg::status_e res_status;
	logic res_credit;

	logic [31:0] model_regs [32];
	bit model_halted;
	logic [31:0] pc_next;
	logic [31:0] exp_pc_a [MAX_INST];
	logic [31:0] exp_val_a [MAX_INST];
	logic [4:0] exp_rd_a [MAX_INST];
	rv_ctrl_pkg::status_e exp_st_a [MAX_INST];
	int exp_cnt;
	int ret_idx;
	int sent_cnt;
	int in_ret;
	int spent;
	int returned;
	int errors;
	int tests_ok;
	int tests_bad;
	int cycles;
	int cd;
	int max_delay;
	bit hold_credits;
	logic [31:0] pend_inst [$];
	logic [31:0] pend_pc [$];

	rv_alu_core u_rv_alu_core (
		.clock(clock), .rst_n(rst_n),
		.inst_valid(inst_valid), .inst(inst_w), .pc(pc_w), .in_credit(in_credit),
		.res_valid(res_valid), .res_pc(res_pc), .res_rd(res_rd),
		.res_value(res_value), .res_status(res_status), .res_credit(res_credit)
	);

	always #50 clock = ~clock;

	// result records against the model, in program order
	a_pc: assert property (@(posedge clock) disable iff (!rst_n)
		res_valid |-> res_pc == exp_pc_a[ret_idx])
		else begin
			$display("FAIL %0t res_pc expected %h actual %h", $time,
				$sampled(exp_pc_a[ret_idx]), $sampled(res_pc));
			errors++;
		end
	a_rd: assert property (@(posedge clock) disable iff (!rst_n)
		res_valid |-> res_rd == exp_rd_a[ret_idx])
		else begin
			$display("FAIL %0t res_rd expected %0d actual %0d", $time,
				$sampled(exp_rd_a[ret_idx]), $sampled(res_rd));
			errors++;
		end
	a_value: assert property (@(posedge clock) disable iff (!rst_n)
		res_valid |-> res_value == exp_val_a[ret_idx])
		else begin
			$display("FAIL %0t res_value expected %h actual %h", $time,
				$sampled(exp_val_a[ret_idx]), $sampled(res_value));
			errors++;
		end
	a_status: assert property (@(posedge clock) disable iff (!rst_n)
		res_valid |-> res_status == exp_st_a[ret_idx])
		else begin
			$display("FAIL %0t res_status expected %0d actual %0d", $time,
				$sampled(exp_st_a[ret_idx]), $sampled(res_status));
			errors++;
		end
	a_no_extra: assert property (@(posedge clock) disable iff (!rst_n)
		res_valid |-> ret_idx < exp_cnt)
		else begin
			$display("a result appeared that the model does not expect at %0t", $time);
			errors++;
		end
	a_credit_use: assert property (@(posedge clock) disable iff (!rst_n)
		res_valid |-> spent < `RV_OUT_CREDITS + returned)
		else begin
			$display("the core sent a result beyond the credits granted at %0t", $time);
			errors++;
		end

	always @(posedge clock) begin
		if (rst_n) begin
			if (res_valid) begin
				ret_idx <= ret_idx + 1;
				spent   <= spent + 1;
			end
			if (in_credit)
				in_ret <= in_ret + 1;
		end
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped: no progress within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	// sender, one instruction per falling edge while a credit is held
	always @(negedge clock) begin
		if (rst_n && pend_inst.size() != 0 && `RV_IN_DEPTH + in_ret - sent_cnt > 0) begin
			inst_valid = 1'b1;
			inst_w     = pend_inst.pop_front();
			pc_w       = pend_pc.pop_front();
			sent_cnt++;
		end else begin
			inst_valid = 1'b0;
		end
	end

	// consumer returns each spent credit after a random wait
	always @(negedge clock) begin
		res_credit = 1'b0;
		if (rst_n && !hold_credits && spent > returned) begin
			if (cd <= 0) begin
				res_credit = 1'b1;
				returned++;
				cd = int'($urandom % max_delay);
			end else begin
				cd--;
			end
		end
	end

	function automatic logic [31:0] base_op(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
		case (f3)
			3'd0: base_op = x + y;
			3'd1: base_op = x << y[4:0];
			3'd2: base_op = {31'b0, $signed(x) < $signed(y)};
			3'd3: base_op = {31'b0, x < y};
			3'd4: base_op = x ^ y;
			3'd5: base_op = x >> y[4:0];
			3'd6: base_op = x | y;
			default: base_op = x & y;
		endcase
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	// queue one instruction and work out its result from the ISA rules
	task automatic send(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] v;
		logic [63:0] p;
		logic [6:0] f7;
		logic [2:0] f3;
		rv_ctrl_pkg::status_e st;
		a   = model_regs[w[19:15]];
		b   = model_regs[w[24:20]];
		imm = {{20{w[31]}}, w[31:20]};
		f7  = w[31:25];
		f3  = w[14:12];
		v   = '0;
		p   = '0;
		st  = rv_ctrl_pkg::ST_OK;
		case (w[6:0])
			7'b0110111: v = {w[31:12], 12'b0};
			7'b0010111: v = pc_next + {w[31:12], 12'b0};
			7'b0010011: begin
				if (f3 == 3'd1 && f7 != 7'h00)
					st = rv_ctrl_pkg::ST_ILLEGAL;
				else if (f3 == 3'd5 && f7 == 7'h20)
					v = $signed(a) >>> imm[4:0];
				else if (f3 == 3'd5 && f7 != 7'h00)
					st = rv_ctrl_pkg::ST_ILLEGAL;
				else
					v = base_op(f3, a, imm);
			end
			7'b0110011: begin
				if (f7 == 7'h00)
					v = base_op(f3, a, b);
				else if (f7 == 7'h20 && f3 == 3'd0)
					v = a - b;
				else if (f7 == 7'h20 && f3 == 3'd5)
					v = $signed(a) >>> b[4:0];
				else if (f7 == 7'h01 && f3 <= 3'd3) begin
					case (f3)
						3'd0: p = {32'b0, a} * {32'b0, b};
						3'd1: p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
						3'd2: p = {{32{a[31]}}, a} * {32'b0, b};
						default: p = {32'b0, a} * {32'b0, b};
					endcase
					v = (f3 == 3'd0) ? p[31:0] : p[63:32];
				end else
					st = rv_ctrl_pkg::ST_ILLEGAL;
			end
			7'b1110011: st = (w == `RV_WFI) ? rv_ctrl_pkg::ST_HALT : rv_ctrl_pkg::ST_ILLEGAL;
			default: st = rv_ctrl_pkg::ST_ILLEGAL;
		endcase
		if (st != rv_ctrl_pkg::ST_OK)
			v = '0;
		if (!model_halted) begin
			exp_pc_a[exp_cnt]  = pc_next;
			exp_rd_a[exp_cnt]  = w[11:7];
			exp_val_a[exp_cnt] = v;
			exp_st_a[exp_cnt]  = st;
			exp_cnt++;
			if (st == rv_ctrl_pkg::ST_OK && w[11:7] != 5'd0)
				model_regs[w[11:7]] = v;
			if (st == rv_ctrl_pkg::ST_HALT)
				model_halted = 1'b1;
		end
		pend_inst.push_back(w);
		pend_pc.push_back(pc_next);
		pc_next += 32'd4;
	endtask

	task automatic finish_test(input string name, input int err_start);
		while (!(pend_inst.size() == 0 && in_ret == sent_cnt && ret_idx == exp_cnt &&
			returned == spent))
			@(posedge clock);
		repeat (6) @(posedge clock);
		if (errors == err_start) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	initial begin
		int e;
		logic [4:0] rd;
		logic [4:0] rs;
		void'($urandom(32'h437ef058));
		clock = 1'b0;
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst_w = '0;
		pc_w = '0;
		res_credit = 1'b0;
		hold_credits = 1'b0;
		max_delay = 3;
		pc_next = 32'h0000_1000;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		repeat (5) @(negedge clock);
		rst_n = 1'b1;

		e = errors; // immediates, upper immediates, x0 as destination
		send({20'h12345, 5'd1, 7'b0110111});
		send(enc_i(12'hff9, 5'd0, 3'd0, 5'd2));
		send(enc_i(12'h7ff, 5'd1, 3'd0, 5'd3));
		send(enc_i(12'h001, 5'd2, 3'd2, 5'd4));
		send(enc_i(12'h001, 5'd2, 3'd3, 5'd5));
		send(enc_i(12'hfff, 5'd2, 3'd4, 5'd6));
		send(enc_i(12'h0f0, 5'd1, 3'd6, 5'd7));
		send(enc_i(12'h8ff, 5'd1, 3'd7, 5'd8));
		send(enc_i(12'h01f, 5'd1, 3'd1, 5'd9));
		send(enc_i(12'h004, 5'd2, 3'd5, 5'd10));
		send(enc_i({7'h20, 5'd4}, 5'd2, 3'd5, 5'd11));
		send({20'h80000, 5'd12, 7'b0010111});
		send(enc_i(12'h005, 5'd2, 3'd0, 5'd0));
		send(enc_i(12'h000, 5'd0, 3'd0, 5'd13));
		finish_test("reg_imm", e);

		e = errors; // register ops on negative operands, multiply forms
		send({20'h80000, 5'd15, 7'b0110111});
		send(enc_r(7'h00, 5'd2, 5'd3, 3'd0, 5'd14));
		send(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd16));
		send(enc_r(7'h00, 5'd4, 5'd2, 3'd2, 5'd17));
		send(enc_r(7'h00, 5'd4, 5'd2, 3'd3, 5'd18));
		send(enc_r(7'h00, 5'd3, 5'd1, 3'd7, 5'd19));
		send(enc_r(7'h00, 5'd3, 5'd2, 3'd6, 5'd20));
		send(enc_r(7'h00, 5'd3, 5'd2, 3'd4, 5'd21));
		send(enc_r(7'h00, 5'd6, 5'd1, 3'd1, 5'd22));
		send(enc_r(7'h00, 5'd6, 5'd2, 3'd5, 5'd23));
		send(enc_r(7'h20, 5'd6, 5'd2, 3'd5, 5'd24));
		send(enc_r(7'h01, 5'd2, 5'd3, 3'd0, 5'd25));
		send(enc_r(7'h01, 5'd2, 5'd15, 3'd1, 5'd26));
		send(enc_r(7'h01, 5'd2, 5'd15, 3'd2, 5'd27));
		send(enc_r(7'h01, 5'd2, 5'd15, 3'd3, 5'd28));
		finish_test("reg_reg", e);

		e = errors; // dependent chains at distance one, two and three
		send(enc_i(12'h001, 5'd0, 3'd0, 5'd20));
		send(enc_i(12'h002, 5'd20, 3'd0, 5'd21));
		send(enc_i(12'h009, 5'd0, 3'd0, 5'd22));
		send(enc_i(12'h001, 5'd21, 3'd0, 5'd23));
		send(enc_i(12'h004, 5'd0, 3'd0, 5'd24));
		send(enc_i(12'h005, 5'd0, 3'd0, 5'd25));
		send(enc_r(7'h00, 5'd24, 5'd23, 3'd0, 5'd26));
		send(enc_r(7'h00, 5'd25, 5'd26, 3'd0, 5'd27));
		for (int i = 0; i < 16; i++) begin
			rd = 5'(20 + $urandom % 8);
			rs = 5'(20 + $urandom % 8);
			if ($urandom % 2 == 0)
				send(enc_i(12'($urandom), rs, 3'd0, rd));
			else
				send(enc_r(7'h00, 5'(20 + $urandom % 8), rs, 3'd0, rd));
		end
		finish_test("forwarding", e);

		e = errors; // withheld, then slow output credits
		hold_credits = 1'b1;
		for (int i = 0; i < 10; i++)
			send(enc_i(12'(i + 1), 5'd20, 3'd0, 5'd20));
		repeat (HOLD_CYCLES) @(posedge clock);
		max_delay = MAX_DELAY;
		hold_credits = 1'b0;
		finish_test("credits", e);
		max_delay = 3;

		e = errors; // encodings the core does not execute
		send({12'd0, 5'd2, 3'b010, 5'd1, 7'b0000011});
		send({7'd0, 5'd3, 5'd2, 3'b010, 5'd4, 7'b0100011});
		send({7'd0, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011});
		send({20'd8, 5'd1, 7'b1101111});
		send({12'd0, 5'd2, 3'b000, 5'd1, 7'b1100111});
		send({12'h300, 5'd1, 3'b001, 5'd5, 7'b1110011});
		send(32'h0000_0073);
		send(32'h0000_00ff);
		send(enc_r(7'h01, 5'd2, 5'd3, 3'd4, 5'd6));
		send(enc_i({7'h20, 5'd1}, 5'd2, 3'd1, 5'd7));
		send(enc_r(7'h00, 5'd4, 5'd1, 3'd0, 5'd29));
		finish_test("illegal", e);

		e = errors; // halt, later instructions only return credits
		send(enc_i(12'h007, 5'd0, 3'd0, 5'd5));
		send(`RV_WFI);
		send(enc_i(12'h001, 5'd5, 3'd0, 5'd6));
		send(enc_i(12'h002, 5'd0, 3'd0, 5'd7));
		send(enc_i(12'h003, 5'd0, 3'd0, 5'd8));
		finish_test("halt", e);

		$display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0 && tests_bad == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/rv_alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_alu_core (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     inst_valid,
	input  rv_isa_pkg::inst_t        inst,
	input  logic [`RV_XLEN-1:0]      pc,
	output logic                     in_credit,
	output logic                     res_valid,
	output logic [`RV_XLEN-1:0]      res_pc,
	output logic [`RV_REG_IDX_W-1:0] res_rd,
	output logic [`RV_XLEN-1:0]      res_value,
	output rv_ctrl_pkg::status_e     res_status,
	input  logic                     res_credit
);

	logic [`RV_REG_IDX_W-1:0] rd_a_idx;
	logic [`RV_REG_IDX_W-1:0] rd_b_idx;
	logic [`RV_XLEN-1:0]      rd_a_data;
	logic [`RV_XLEN-1:0]      rd_b_data;
	logic                     wr_en;
	logic [`RV_REG_IDX_W-1:0] wr_idx;
	logic [`RV_XLEN-1:0]      wr_data;
	logic                     advance;
	logic                     halted;

	// decode register
	logic                     d_valid;
	logic [`RV_XLEN-1:0]      d_pc;
	logic [`RV_REG_IDX_W-1:0] d_rd;
	logic [`RV_REG_IDX_W-1:0] d_rs1;
	logic [`RV_REG_IDX_W-1:0] d_rs2;
	logic [`RV_XLEN-1:0]      d_op_a;
	logic [`RV_XLEN-1:0]      d_op_b;
	logic [`RV_XLEN-1:0]      d_imm;
	rv_ctrl_pkg::opa_sel_e    d_opa_sel;
	rv_ctrl_pkg::opb_sel_e    d_opb_sel;
	rv_ctrl_pkg::alu_func_e   d_alu_func;
	logic                     d_wr_en;
	rv_ctrl_pkg::status_e     d_status;

	// execute register
	logic                     e_valid;
	logic [`RV_XLEN-1:0]      e_pc;
	logic [`RV_REG_IDX_W-1:0] e_rd;
	logic [`RV_XLEN-1:0]      e_value;
	logic                     e_wr_en;
	rv_ctrl_pkg::status_e     e_status;

	rv_regfile u_regfile (
		.clock(clock), .rst_n(rst_n),
		.rd_a_idx(rd_a_idx), .rd_a_data(rd_a_data),
		.rd_b_idx(rd_b_idx), .rd_b_data(rd_b_data),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
	);

	rv_decode u_decode (
		.clock(clock), .rst_n(rst_n),
		.inst_valid(inst_valid), .inst(inst), .pc(pc), .in_credit(in_credit),
		.advance(advance), .halted(halted),
		.rd_a_idx(rd_a_idx), .rd_a_data(rd_a_data),
		.rd_b_idx(rd_b_idx), .rd_b_data(rd_b_data),
		.d_valid(d_valid), .d_pc(d_pc), .d_rd(d_rd), .d_rs1(d_rs1), .d_rs2(d_rs2),
		.d_op_a(d_op_a), .d_op_b(d_op_b), .d_imm(d_imm),
		.d_opa_sel(d_opa_sel), .d_opb_sel(d_opb_sel), .d_alu_func(d_alu_func),
		.d_wr_en(d_wr_en), .d_status(d_status)
	);

	rv_execute u_execute (
		.clock(clock), .rst_n(rst_n), .advance(advance),
		.d_valid(d_valid), .d_pc(d_pc), .d_rd(d_rd), .d_rs1(d_rs1), .d_rs2(d_rs2),
		.d_op_a(d_op_a), .d_op_b(d_op_b), .d_imm(d_imm),
		.d_opa_sel(d_opa_sel), .d_opb_sel(d_opb_sel), .d_alu_func(d_alu_func),
		.d_wr_en(d_wr_en), .d_status(d_status),
		.e_valid(e_valid), .e_pc(e_pc), .e_rd(e_rd), .e_value(e_value),
		.e_wr_en(e_wr_en), .e_status(e_status)
	);

	rv_result u_result (
		.clock(clock), .rst_n(rst_n),
		.e_valid(e_valid), .e_pc(e_pc), .e_rd(e_rd), .e_value(e_value),
		.e_wr_en(e_wr_en), .e_status(e_status),
		.res_credit(res_credit), .advance(advance),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .halted(halted),
		.res_valid(res_valid), .res_pc(res_pc), .res_rd(res_rd),
		.res_value(res_value), .res_status(res_status)
	);

endmodule

`default_nettype wire

// ==== rtl/rv_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_result (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     e_valid,
	input  logic [`RV_XLEN-1:0]      e_pc,
	input  logic [`RV_REG_IDX_W-1:0] e_rd,
	input  logic [`RV_XLEN-1:0]      e_value,
	input  logic                     e_wr_en,
	input  rv_ctrl_pkg::status_e     e_status,
	input  logic                     res_credit,
	output logic                     advance,
	output logic                     wr_en,
	output logic [`RV_REG_IDX_W-1:0] wr_idx,
	output logic [`RV_XLEN-1:0]      wr_data,
	output logic                     halted,
	output logic                     res_valid,
	output logic [`RV_XLEN-1:0]      res_pc,
	output logic [`RV_REG_IDX_W-1:0] res_rd,
	output logic [`RV_XLEN-1:0]      res_value,
	output rv_ctrl_pkg::status_e     res_status
);

	localparam int CNT_W = $clog2(`RV_OUT_CREDITS + 1);

	logic [CNT_W-1:0] credits;
	logic             has_credit;
	logic             retire;

	assign has_credit = credits != '0;
	assign retire     = e_valid && !halted && has_credit;
	assign advance    = !e_valid || halted || has_credit; // after a halt the entry just drains

	assign wr_en   = retire && e_wr_en;
	assign wr_idx  = e_rd;
	assign wr_data = e_value;

	assign res_valid  = retire;
	assign res_pc     = e_pc;
	assign res_rd     = e_rd;
	assign res_value  = e_value;
	assign res_status = e_status;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CNT_W'(`RV_OUT_CREDITS);
			halted  <= 1'b0;
		end else begin
			credits <= credits + CNT_W'(res_credit) - CNT_W'(retire);
			if (retire && e_status == rv_ctrl_pkg::ST_HALT)
				halted <= 1'b1; // sticky
		end
	end

	// the consumer returns no more than was spent
	a_credit_max: assert property (@(posedge clock) disable iff (!rst_n)
		credits <= CNT_W'(`RV_OUT_CREDITS))
		else $error("output credits above the initial grant");

endmodule

`default_nettype wire

// ==== rtl/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_execute (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     advance,
	input  logic                     d_valid,
	input  logic [`RV_XLEN-1:0]      d_pc,
	input  logic [`RV_REG_IDX_W-1:0] d_rd,
	input  logic [`RV_REG_IDX_W-1:0] d_rs1,
	input  logic [`RV_REG_IDX_W-1:0] d_rs2,
	input  logic [`RV_XLEN-1:0]      d_op_a,
	input  logic [`RV_XLEN-1:0]      d_op_b,
	input  logic [`RV_XLEN-1:0]      d_imm,
	input  rv_ctrl_pkg::opa_sel_e    d_opa_sel,
	input  rv_ctrl_pkg::opb_sel_e    d_opb_sel,
	input  rv_ctrl_pkg::alu_func_e   d_alu_func,
	input  logic                     d_wr_en,
	input  rv_ctrl_pkg::status_e     d_status,
	output logic                     e_valid,
	output logic [`RV_XLEN-1:0]      e_pc,
	output logic [`RV_REG_IDX_W-1:0] e_rd,
	output logic [`RV_XLEN-1:0]      e_value,
	output logic                     e_wr_en,
	output rv_ctrl_pkg::status_e     e_status
);

	localparam int SHAMT_W = $clog2(`RV_XLEN);

	logic [`RV_XLEN-1:0]          rs1_val;
	logic [`RV_XLEN-1:0]          rs2_val;
	logic [`RV_XLEN-1:0]          opa;
	logic [`RV_XLEN-1:0]          opb;
	logic [SHAMT_W-1:0]           shamt;
	logic                         signed_a;
	logic                         signed_b;
	logic signed [`RV_XLEN:0]     mul_a; // one extra bit carries the sign treatment
	logic signed [`RV_XLEN:0]     mul_b;
	logic signed [2*`RV_XLEN+1:0] mul_p;
	logic [`RV_XLEN-1:0]          alu_out;

	// the entry one ahead has not reached the register file yet
	assign rs1_val = (e_valid && e_wr_en && e_rd == d_rs1) ? e_value : d_op_a;
	assign rs2_val = (e_valid && e_wr_en && e_rd == d_rs2) ? e_value : d_op_b;

	always_comb begin
		case (d_opa_sel)
			rv_ctrl_pkg::OPA_RS1: opa = rs1_val;
			rv_ctrl_pkg::OPA_PC:  opa = d_pc;
			default:              opa = '0;
		endcase
	end

	assign opb   = (d_opb_sel == rv_ctrl_pkg::OPB_IMM) ? d_imm : rs2_val;
	assign shamt = opb[SHAMT_W-1:0];

	assign signed_a = d_alu_func inside {rv_ctrl_pkg::ALU_MULH, rv_ctrl_pkg::ALU_MULHSU};
	assign signed_b = d_alu_func == rv_ctrl_pkg::ALU_MULH;
	assign mul_a    = {signed_a && opa[`RV_XLEN-1], opa};
	assign mul_b    = {signed_b && opb[`RV_XLEN-1], opb};
	assign mul_p    = mul_a * mul_b;

	always_comb begin
		case (d_alu_func)
			rv_ctrl_pkg::ALU_SUB:  alu_out = opa - opb;
			rv_ctrl_pkg::ALU_SLT:  alu_out = {31'b0, $signed(opa) < $signed(opb)};
			rv_ctrl_pkg::ALU_SLTU: alu_out = {31'b0, opa < opb};
			rv_ctrl_pkg::ALU_AND:  alu_out = opa & opb;
			rv_ctrl_pkg::ALU_OR:   alu_out = opa | opb;
			rv_ctrl_pkg::ALU_XOR:  alu_out = opa ^ opb;
			rv_ctrl_pkg::ALU_SLL:  alu_out = opa << shamt;
			rv_ctrl_pkg::ALU_SRL:  alu_out = opa >> shamt;
			rv_ctrl_pkg::ALU_SRA:  alu_out = $signed(opa) >>> shamt;
			rv_ctrl_pkg::ALU_MUL:  alu_out = mul_p[`RV_XLEN-1:0];
			rv_ctrl_pkg::ALU_MULH, rv_ctrl_pkg::ALU_MULHSU,
			rv_ctrl_pkg::ALU_MULHU: alu_out = mul_p[2*`RV_XLEN-1:`RV_XLEN];
			default:               alu_out = opa + opb; // ADD, also LUI and AUIPC
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			e_valid <= 1'b0;
			e_wr_en <= 1'b0;
		end else if (advance) begin
			e_valid <= d_valid;
			e_wr_en <= d_valid && d_wr_en;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			e_pc     <= d_pc;
			e_rd     <= d_rd;
			e_status <= d_status;
			e_value  <= (d_status == rv_ctrl_pkg::ST_OK) ? alu_out : '0; // illegal, halt carry 0
		end
	end

endmodule

`default_nettype wire

// ==== rtl/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_decode (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     inst_valid,
	input  rv_isa_pkg::inst_t        inst,
	input  logic [`RV_XLEN-1:0]      pc,
	output logic                     in_credit,
	input  logic                     advance,
	input  logic                     halted,
	output logic [`RV_REG_IDX_W-1:0] rd_a_idx,
	input  logic [`RV_XLEN-1:0]      rd_a_data,
	output logic [`RV_REG_IDX_W-1:0] rd_b_idx,
	input  logic [`RV_XLEN-1:0]      rd_b_data,
	output logic                     d_valid,
	output logic [`RV_XLEN-1:0]      d_pc,
	output logic [`RV_REG_IDX_W-1:0] d_rd,
	output logic [`RV_REG_IDX_W-1:0] d_rs1,
	output logic [`RV_REG_IDX_W-1:0] d_rs2,
	output logic [`RV_XLEN-1:0]      d_op_a,
	output logic [`RV_XLEN-1:0]      d_op_b,
	output logic [`RV_XLEN-1:0]      d_imm,
	output rv_ctrl_pkg::opa_sel_e    d_opa_sel,
	output rv_ctrl_pkg::opb_sel_e    d_opb_sel,
	output rv_ctrl_pkg::alu_func_e   d_alu_func,
	output logic                     d_wr_en,
	output rv_ctrl_pkg::status_e     d_status
);

	localparam int PTR_W = $clog2(`RV_IN_DEPTH);

	rv_isa_pkg::inst_t      fifo_inst [`RV_IN_DEPTH];
	logic [`RV_XLEN-1:0]    fifo_pc   [`RV_IN_DEPTH];
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [PTR_W:0]         count;
	logic                   push;
	logic                   pop;
	rv_isa_pkg::inst_t      hd;   // head entry
	rv_ctrl_pkg::opa_sel_e  dec_opa;
	rv_ctrl_pkg::opb_sel_e  dec_opb;
	rv_ctrl_pkg::alu_func_e dec_func;
	rv_ctrl_pkg::status_e   dec_status;
	logic [`RV_XLEN-1:0]    dec_imm;
	logic                   dec_dest;
	logic                   dec_wr_en;

	// funct3 of the base integer ops; alt picks SUB/SRA
	function automatic rv_ctrl_pkg::alu_func_e base_func(input logic [2:0] f3, input logic alt);
		case (f3)
			rv_isa_pkg::F3_ADD_SUB: base_func = alt ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
			rv_isa_pkg::F3_SLL:     base_func = rv_ctrl_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT:     base_func = rv_ctrl_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU:    base_func = rv_ctrl_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:     base_func = rv_ctrl_pkg::ALU_XOR;
			rv_isa_pkg::F3_SRL_SRA: base_func = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
			rv_isa_pkg::F3_OR:      base_func = rv_ctrl_pkg::ALU_OR;
			default:                base_func = rv_ctrl_pkg::ALU_AND;
		endcase
	endfunction

	assign push = inst_valid;
	assign pop  = (count != '0) && advance; // advance is also high once halted
	assign hd   = fifo_inst[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			fifo_inst[wr_ptr] <= inst;
			fifo_pc[wr_ptr]   <= pc;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(`RV_IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(`RV_IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			in_credit <= pop; // one credit back per entry leaving, issued or dropped
		end
	end

	assign rd_a_idx = hd.r.rs1;
	assign rd_b_idx = hd.r.rs2;

	// noop defaults first, then each opcode overrides what it needs
	always_comb begin
		dec_opa    = rv_ctrl_pkg::OPA_RS1;
		dec_opb    = rv_ctrl_pkg::OPB_RS2;
		dec_func   = rv_ctrl_pkg::ALU_ADD;
		dec_imm    = '0;
		dec_dest   = 1'b0;
		dec_status = rv_ctrl_pkg::ST_OK;
		case (hd.r.opcode)
			rv_isa_pkg::OPC_LUI: begin
				dec_dest = 1'b1;
				dec_opa  = rv_ctrl_pkg::OPA_ZERO;
				dec_opb  = rv_ctrl_pkg::OPB_IMM;
				dec_imm  = {hd.u.imm, 12'b0};
			end
			rv_isa_pkg::OPC_AUIPC: begin
				dec_dest = 1'b1;
				dec_opa  = rv_ctrl_pkg::OPA_PC;
				dec_opb  = rv_ctrl_pkg::OPB_IMM;
				dec_imm  = {hd.u.imm, 12'b0};
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				dec_dest = 1'b1;
				dec_opb  = rv_ctrl_pkg::OPB_IMM;
				dec_imm  = {{(`RV_XLEN - 12){hd.i.imm[11]}}, hd.i.imm};
				// only the right shift looks at imm[11:5] as a funct7
				dec_func = base_func(hd.r.funct3, hd.r.funct3 == rv_isa_pkg::F3_SRL_SRA &&
					hd.r.funct7 == rv_isa_pkg::F7_ALT);
				if (hd.r.funct3 == rv_isa_pkg::F3_SLL && hd.r.funct7 != rv_isa_pkg::F7_BASE)
					dec_status = rv_ctrl_pkg::ST_ILLEGAL;
				if (hd.r.funct3 == rv_isa_pkg::F3_SRL_SRA && hd.r.funct7 != rv_isa_pkg::F7_BASE &&
					hd.r.funct7 != rv_isa_pkg::F7_ALT)
					dec_status = rv_ctrl_pkg::ST_ILLEGAL;
			end
			rv_isa_pkg::OPC_OP: begin
				dec_dest = 1'b1;
				case (hd.r.funct7)
					rv_isa_pkg::F7_BASE: dec_func = base_func(hd.r.funct3, 1'b0);
					rv_isa_pkg::F7_ALT: begin
						dec_func = base_func(hd.r.funct3, 1'b1);
						if (hd.r.funct3 != rv_isa_pkg::F3_ADD_SUB &&
							hd.r.funct3 != rv_isa_pkg::F3_SRL_SRA)
							dec_status = rv_ctrl_pkg::ST_ILLEGAL;
					end
					rv_isa_pkg::F7_MULDIV: begin
						case (hd.r.funct3)
							rv_isa_pkg::F3_MUL:    dec_func = rv_ctrl_pkg::ALU_MUL;
							rv_isa_pkg::F3_MULH:   dec_func = rv_ctrl_pkg::ALU_MULH;
							rv_isa_pkg::F3_MULHSU: dec_func = rv_ctrl_pkg::ALU_MULHSU;
							rv_isa_pkg::F3_MULHU:  dec_func = rv_ctrl_pkg::ALU_MULHU;
							default:               dec_status = rv_ctrl_pkg::ST_ILLEGAL; // divides
						endcase
					end
					default: dec_status = rv_ctrl_pkg::ST_ILLEGAL;
				endcase
			end
			rv_isa_pkg::OPC_SYSTEM: begin
				if (hd == `RV_WFI)
					dec_status = rv_ctrl_pkg::ST_HALT;
				else
					dec_status = rv_ctrl_pkg::ST_ILLEGAL; // CSR ops, ecall, ebreak
			end
			rv_isa_pkg::OPC_STORE: begin
				dec_imm    = {{(`RV_XLEN - 12){hd.s.imm_hi[6]}}, hd.s.imm_hi, hd.s.imm_lo};
				dec_status = rv_ctrl_pkg::ST_ILLEGAL;
			end
			rv_isa_pkg::OPC_LOAD, rv_isa_pkg::OPC_BRANCH,
			rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: dec_status = rv_ctrl_pkg::ST_ILLEGAL;
			default: dec_status = rv_ctrl_pkg::ST_ILLEGAL;
		endcase
	end

	assign dec_wr_en = dec_dest && dec_status == rv_ctrl_pkg::ST_OK &&
		hd.r.rd != `RV_ZERO_REG;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
			d_wr_en <= 1'b0;
		end else if (advance) begin
			d_valid <= (count != '0) && !halted; // popped but not issued after a halt
			d_wr_en <= (count != '0) && !halted && dec_wr_en;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			d_pc       <= fifo_pc[rd_ptr];
			d_rd       <= hd.r.rd;
			d_rs1      <= hd.r.rs1;
			d_rs2      <= hd.r.rs2;
			d_op_a     <= rd_a_data;
			d_op_b     <= rd_b_data;
			d_imm      <= dec_imm;
			d_opa_sel  <= dec_opa;
			d_opb_sel  <= dec_opb;
			d_alu_func <= dec_func;
			d_status   <= dec_status;
		end
	end

	// the sender only pushes while it holds a credit, so a full buffer never sees a push
	a_no_overflow: assert property (@(posedge clock) disable iff (!rst_n)
		inst_valid |-> count < `RV_IN_DEPTH)
		else $error("input buffer overflow, sender ignored its credits");

endmodule

`default_nettype wire

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rv_regfile (
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic [`RV_REG_IDX_W-1:0] rd_a_idx,
	output logic [`RV_XLEN-1:0]      rd_a_data,
	input  logic [`RV_REG_IDX_W-1:0] rd_b_idx,
	output logic [`RV_XLEN-1:0]      rd_b_data,
	input  logic                     wr_en,
	input  logic [`RV_REG_IDX_W-1:0] wr_idx,
	input  logic [`RV_XLEN-1:0]      wr_data
);

	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS-1:1]; // no storage behind x0

	always_ff @(posedge clock) begin
		if (wr_en && wr_idx != `RV_ZERO_REG)
			regs[wr_idx] <= wr_data;
	end

	// a write in this cycle is visible to the reads right away
	always_comb begin
		if (rd_a_idx == `RV_ZERO_REG)                rd_a_data = '0;
		else if (wr_en && wr_idx == rd_a_idx)        rd_a_data = wr_data;
		else                                         rd_a_data = regs[rd_a_idx];

		if (rd_b_idx == `RV_ZERO_REG)                rd_b_data = '0;
		else if (wr_en && wr_idx == rd_b_idx)        rd_b_data = wr_data;
		else                                         rd_b_data = regs[rd_b_idx];
	end

	// decode clears the write enable for rd = x0, so nothing downstream targets it
	a_no_x0_write: assert property (@(posedge clock) disable iff (!rst_n)
		wr_en |-> wr_idx != `RV_ZERO_REG)
		else $error("register file write aimed at x0");

endmodule

`default_nettype wire

// ==== rtl/rv_ctrl_pkg.sv ====
`default_nettype none

package rv_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_MUL,    // low word
		ALU_MULH,   // high word, signed x signed
		ALU_MULHSU, // high word, signed x unsigned
		ALU_MULHU   // high word, unsigned x unsigned
	} alu_func_e;

	typedef enum logic [1:0] {
		OPA_RS1,
		OPA_PC,
		OPA_ZERO
	} opa_sel_e;

	// immediate is already formed in decode
	typedef enum logic {
		OPB_RS2,
		OPB_IMM
	} opb_sel_e;

	typedef enum logic [1:0] {
		ST_OK,
		ST_HALT,
		ST_ILLEGAL
	} status_e;

endpackage

`default_nettype wire

// ==== rtl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// base integer ops, shared by OP and OP_IMM
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,
		F3_SLL     = 3'b001,
		F3_SLT     = 3'b010,
		F3_SLTU    = 3'b011,
		F3_XOR     = 3'b100,
		F3_SRL_SRA = 3'b101,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} funct3_e;

	// multiply forms under funct7 MULDIV, the divides are not supported
	typedef enum logic [2:0] {
		F3_MUL    = 3'b000,
		F3_MULH   = 3'b001,
		F3_MULHSU = 3'b010,
		F3_MULHU  = 3'b011
	} funct3_m_e;

	typedef enum logic [6:0] {
		F7_BASE   = 7'h00,
		F7_MULDIV = 7'h01,
		F7_ALT    = 7'h20 // SUB, SRA, SRAI
	} funct7_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_type_t;

	typedef struct packed {
		logic [19:0] imm; // upper 20 bits of the result
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_type_t;

	// one instruction word, viewed through whichever format the opcode picks
	typedef union packed {
		r_type_t r;
		i_type_t i;
		s_type_t s;
		u_type_t u;
	} inst_t;

endpackage

`default_nettype wire

// ==== include/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath and register file
`define RV_XLEN        32
`define RV_NUM_REGS    32
`define RV_REG_IDX_W   5
`define RV_ZERO_REG    0

// input buffer entries, also the sender's starting credits
`define RV_IN_DEPTH    4

// credits the core holds toward the result consumer
`define RV_OUT_CREDITS 2

// wait-for-interrupt, used as the halt instruction
`define RV_WFI         32'h1050_0073

`endif
